/* isaPkg.sv */
`default_nettype none

package isaPkg;

    // Datapath and instruction width
    localparam int wordWidth = 32;

    // Register index width for a 32-entry file
    localparam int regAddrWidth = 5;

    // Primary opcodes in bits 31:26
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeT;

    // R-type function codes in bits 5:0
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functT;

    // All ones ends the program
    localparam logic [wordWidth-1:0] haltWord = '1;

endpackage

`default_nettype wire

/* pipePkg.sv */
`default_nettype none

package pipePkg;

    // ALU operand source, chosen per operand
    typedef enum logic [1:0] {
        fromReg   = 2'd0,
        fromExMem = 2'd1,
        fromMemWb = 2'd2
    } fwdSelT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpT;

    // Decoded controls, all zero is a bubble
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  aluImm;
        logic  branch;
        logic  jump;
        logic  halt;
        aluOpT aluOp;
    } ctrlT;

endpackage

`default_nettype wire

/* pipeIfs.sv */
`default_nettype none

// ID/EX stage register
interface idExIf
    import isaPkg::*, pipePkg::*;
();
    ctrlT                    ctrl;
    logic [wordWidth-1:0]    pcNext;
    logic [wordWidth-1:0]    rsVal;
    logic [wordWidth-1:0]    rtVal;
    logic [regAddrWidth-1:0] rsIdx;
    logic [regAddrWidth-1:0] rtIdx;
    logic [wordWidth-1:0]    imm;
    logic [regAddrWidth-1:0] destIdx;
    logic [wordWidth-1:0]    jumpTarget;

    modport producer (output ctrl, pcNext, rsVal, rtVal, rsIdx, rtIdx, imm, destIdx, jumpTarget);
    modport consumer (input ctrl, pcNext, rsVal, rtVal, rsIdx, rtIdx, imm, destIdx, jumpTarget);
    // Forwarding and load-use checks
    modport monitor (input ctrl, rsIdx, rtIdx, destIdx);
endinterface

// EX/MEM stage register
interface exMemIf
    import isaPkg::*, pipePkg::*;
();
    ctrlT                    ctrl;
    logic [wordWidth-1:0]    aluResult;
    logic [wordWidth-1:0]    storeData;
    logic [regAddrWidth-1:0] destIdx;

    modport producer (output ctrl, aluResult, storeData, destIdx);
    modport consumer (input ctrl, aluResult, storeData, destIdx);
    modport monitor (input ctrl, destIdx);
endinterface

// MEM/WB stage register, write data already selected
interface memWbIf
    import isaPkg::*;
();
    logic                    regWrite;
    logic [regAddrWidth-1:0] destIdx;
    logic [wordWidth-1:0]    writeData;
    logic                    halt;

    modport producer (output regWrite, destIdx, writeData, halt);
    modport consumer (input regWrite, destIdx, writeData);
    modport monitor (input regWrite, destIdx, writeData, halt);
endinterface

`default_nettype wire

/* fetchStage.sv */
`default_nettype none

module fetchStage
    import isaPkg::*;
#(
    parameter int imemDepth = 64
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         imemWe,
    input  logic [$clog2(imemDepth)-1:0] imemAddr,
    input  logic [wordWidth-1:0]         imemData,
    input  logic                         running,
    input  logic                         stall,
    input  logic                         flushFront,
    input  logic                         redirect,
    input  logic [wordWidth-1:0]         redirectPc,
    output logic [wordWidth-1:0]         ifIdInstr,
    output logic [wordWidth-1:0]         ifIdPcNext
);
    localparam int addrBits = $clog2(imemDepth);

    logic [wordWidth-1:0] imem [imemDepth];
    logic [wordWidth-1:0] pc;
    logic [wordWidth-1:0] fetched;
    logic                 holdPc;

    // Word addressed, upper pc bits ignored
    assign fetched = imem[pc[addrBits-1:0]];

    // Pc freezes once decode holds the halt word
    assign holdPc = stall || (ifIdInstr == haltWord);

    // Program load port
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    // Idle core parks at word 0
    always_ff @(posedge clk) begin
        if (rst || !running) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!holdPc) begin
            pc <= pc + 1'b1;
        end
    end

    // IF/ID, zero word decodes as a bubble
    always_ff @(posedge clk) begin
        if (rst || !running || flushFront) begin
            ifIdInstr <= '0;
        end else if (!stall) begin
            ifIdInstr <= fetched;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifIdPcNext <= pc + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* decodeStage.sv */
`default_nettype none

module decodeStage
    import isaPkg::*, pipePkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [wordWidth-1:0] ifIdInstr,
    input  logic [wordWidth-1:0] ifIdPcNext,
    input  logic                 stall,
    input  logic                 flushFront,
    idExIf.producer              idEx,
    memWbIf.consumer             memWb,
    output logic                 decHalt
);
    logic [wordWidth-1:0]    regs [32];
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] dest;
    ctrlT                    dec;

    assign rs = ifIdInstr[25:21];
    assign rt = ifIdInstr[20:16];
    assign rd = ifIdInstr[15:11];
    assign decHalt = (ifIdInstr == haltWord);

    // Register read with same-cycle write-back bypass
    function automatic logic [wordWidth-1:0] readReg(input logic [regAddrWidth-1:0] idx);
        logic [wordWidth-1:0] val;
        val = regs[idx];
        if (memWb.regWrite && memWb.destIdx == idx) begin
            val = memWb.writeData;
        end
        // r0 is hardwired
        if (idx == '0) begin
            val = '0;
        end
        return val;
    endfunction

    // Main decoder, unknown encodings give a bubble
    always_comb begin
        dec = '0;
        dest = rt;
        if (decHalt) begin
            dec.halt = 1'b1;
        end else begin
            case (ifIdInstr[31:26])
                opRType: begin
                    dest = rd;
                    dec.regWrite = 1'b1;
                    case (ifIdInstr[5:0])
                        fnAdd:   dec.aluOp = aluAdd;
                        fnSub:   dec.aluOp = aluSub;
                        fnAnd:   dec.aluOp = aluAnd;
                        fnOr:    dec.aluOp = aluOr;
                        fnSlt:   dec.aluOp = aluSlt;
                        default: dec.regWrite = 1'b0;
                    endcase
                end
                opAddi: begin
                    dec.regWrite = 1'b1;
                    dec.aluImm = 1'b1;
                end
                opLw: begin
                    dec.regWrite = 1'b1;
                    dec.memRead = 1'b1;
                    dec.memToReg = 1'b1;
                    dec.aluImm = 1'b1;
                end
                opSw: begin
                    dec.memWrite = 1'b1;
                    dec.aluImm = 1'b1;
                end
                // Compare by subtraction
                opBeq: begin
                    dec.branch = 1'b1;
                    dec.aluOp = aluSub;
                end
                opJ: dec.jump = 1'b1;
                default: dec = '0;
            endcase
        end
    end

    // Register file, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (memWb.regWrite && memWb.destIdx != '0) begin
            regs[memWb.destIdx] <= memWb.writeData;
        end
    end

    // ID/EX controls
    always_ff @(posedge clk) begin
        if (rst || stall || flushFront) begin
            idEx.ctrl <= '0;
        end else begin
            idEx.ctrl <= dec;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        idEx.pcNext <= ifIdPcNext;
        idEx.rsVal <= readReg(rs);
        idEx.rtVal <= readReg(rt);
        idEx.rsIdx <= rs;
        idEx.rtIdx <= rt;
        idEx.imm <= {{(wordWidth-16){ifIdInstr[15]}}, ifIdInstr[15:0]};
        idEx.destIdx <= dest;
        // Jump target is a plain word index
        idEx.jumpTarget <= {{(wordWidth-26){1'b0}}, ifIdInstr[25:0]};
    end

endmodule

`default_nettype wire

/* executeStage.sv */
`default_nettype none

module executeStage
    import isaPkg::*, pipePkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  fwdSelT               fwdA,
    input  fwdSelT               fwdB,
    idExIf.consumer              idEx,
    memWbIf.monitor              memWb,
    exMemIf.producer             exMem,
    output logic                 redirect,
    output logic [wordWidth-1:0] redirectPc
);
    logic [wordWidth-1:0] opA;
    logic [wordWidth-1:0] opB;
    logic [wordWidth-1:0] aluB;
    logic [wordWidth-1:0] aluResult;
    logic                 taken;

    // Forwarding mux for one operand
    function automatic logic [wordWidth-1:0] pickOperand(
        input fwdSelT               sel,
        input logic [wordWidth-1:0] regVal,
        input logic [wordWidth-1:0] exMemVal,
        input logic [wordWidth-1:0] memWbVal
    );
        case (sel)
            fromExMem: return exMemVal;
            fromMemWb: return memWbVal;
            default:   return regVal;
        endcase
    endfunction

    assign opA = pickOperand(fwdA, idEx.rsVal, exMem.aluResult, memWb.writeData);
    assign opB = pickOperand(fwdB, idEx.rtVal, exMem.aluResult, memWb.writeData);
    assign aluB = idEx.ctrl.aluImm ? idEx.imm : opB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluSub:  aluResult = opA - aluB;
            aluAnd:  aluResult = opA & aluB;
            aluOr:   aluResult = opA | aluB;
            // Signed compare
            aluSlt:  aluResult = {{(wordWidth-1){1'b0}}, $signed(opA) < $signed(aluB)};
            default: aluResult = opA + aluB;
        endcase
    end

    // Branch resolves on forwarded operands
    assign taken = idEx.ctrl.branch && (opA == opB);
    assign redirect = taken || idEx.ctrl.jump;
    assign redirectPc = idEx.ctrl.jump ? idEx.jumpTarget : idEx.pcNext + idEx.imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            exMem.ctrl <= '0;
        end else begin
            exMem.ctrl <= idEx.ctrl;
        end
    end

    // Store data follows the forwarded rt value
    always_ff @(posedge clk) begin
        exMem.aluResult <= aluResult;
        exMem.storeData <= opB;
        exMem.destIdx <= idEx.destIdx;
    end

endmodule

`default_nettype wire

/* memoryStage.sv */
`default_nettype none

module memoryStage
    import isaPkg::*;
#(
    parameter int dmemDepth = 64
) (
    input  logic     clk,
    input  logic     rst,
    exMemIf.consumer exMem,
    memWbIf.producer memWb
);
    localparam int addrBits = $clog2(dmemDepth);

    logic [wordWidth-1:0] dmem [dmemDepth];
    logic [addrBits-1:0]  addr;
    logic [wordWidth-1:0] loadData;

    // Word address from the ALU result
    assign addr = exMem.aluResult[addrBits-1:0];
    assign loadData = exMem.ctrl.memRead ? dmem[addr] : '0;

    always_ff @(posedge clk) begin
        if (exMem.ctrl.memWrite) begin
            dmem[addr] <= exMem.storeData;
        end
    end

    // MEM/WB controls
    always_ff @(posedge clk) begin
        if (rst) begin
            memWb.regWrite <= 1'b0;
            memWb.halt <= 1'b0;
        end else begin
            memWb.regWrite <= exMem.ctrl.regWrite;
            memWb.halt <= exMem.ctrl.halt;
        end
    end

    // Load data or ALU result
    always_ff @(posedge clk) begin
        memWb.destIdx <= exMem.destIdx;
        memWb.writeData <= exMem.ctrl.memToReg ? loadData : exMem.aluResult;
    end

endmodule

`default_nettype wire

/* hazardControl.sv */
`default_nettype none

module hazardControl
    import isaPkg::*, pipePkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 decHalt,
    input  logic                 redirect,
    input  logic [wordWidth-1:0] ifIdInstr,
    idExIf.monitor               idEx,
    exMemIf.monitor              exMem,
    memWbIf.monitor              memWb,
    output logic                 stall,
    output logic                 flushFront,
    output logic                 running,
    output logic                 halted,
    output fwdSelT               fwdA,
    output fwdSelT               fwdB
);
    logic [regAddrWidth-1:0] ifIdRs;
    logic [regAddrWidth-1:0] ifIdRt;
    logic                    exMemFwdOk;
    logic                    memWbFwdOk;
    logic                    loadUse;
    logic                    haltPending;

    assign ifIdRs = ifIdInstr[25:21];
    assign ifIdRt = ifIdInstr[20:16];

    // Loads in EX/MEM have no data yet
    assign exMemFwdOk = exMem.ctrl.regWrite && !exMem.ctrl.memRead && exMem.destIdx != '0;
    assign memWbFwdOk = memWb.regWrite && memWb.destIdx != '0;

    // Younger result in EX/MEM wins
    always_comb begin
        fwdA = fromReg;
        fwdB = fromReg;
        if (exMemFwdOk && exMem.destIdx == idEx.rsIdx) begin
            fwdA = fromExMem;
        end else if (memWbFwdOk && memWb.destIdx == idEx.rsIdx) begin
            fwdA = fromMemWb;
        end
        if (exMemFwdOk && exMem.destIdx == idEx.rtIdx) begin
            fwdB = fromExMem;
        end else if (memWbFwdOk && memWb.destIdx == idEx.rtIdx) begin
            fwdB = fromMemWb;
        end
    end

    // Load in ID/EX feeding the instruction in IF/ID
    assign loadUse = idEx.ctrl.memRead && idEx.destIdx != '0
                     && (idEx.destIdx == ifIdRs || idEx.destIdx == ifIdRt);

    // Halt pending keeps fetch frozen and feeds bubbles behind it
    assign stall = loadUse || haltPending;
    assign flushFront = redirect;

    // A redirect squashes a younger halt
    always_ff @(posedge clk) begin
        if (rst || redirect || !running) begin
            haltPending <= 1'b0;
        end else if (decHalt && !stall) begin
            haltPending <= 1'b1;
        end
    end

    // Run control
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            halted <= 1'b0;
        end else if (running && memWb.halt) begin
            running <= 1'b0;
            halted <= 1'b1;
        end else if (start && !running) begin
            running <= 1'b1;
            halted <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* pipelineCpu.sv */
`default_nettype none

module pipelineCpu
    import isaPkg::*, pipePkg::*;
#(
    parameter int imemDepth = 64,
    parameter int dmemDepth = 64
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         imemWe,
    input  logic [$clog2(imemDepth)-1:0] imemAddr,
    input  logic [wordWidth-1:0]         imemData,
    input  logic                         start,
    output logic                         wbValid,
    output logic [regAddrWidth-1:0]      wbReg,
    output logic [wordWidth-1:0]         wbData,
    output logic                         halted
);
    logic [wordWidth-1:0] ifIdInstr;
    logic [wordWidth-1:0] ifIdPcNext;
    logic [wordWidth-1:0] redirectPc;
    logic                 stall;
    logic                 flushFront;
    logic                 running;
    logic                 redirect;
    logic                 decHalt;
    fwdSelT               fwdA;
    fwdSelT               fwdB;

    idExIf  idEx ();
    exMemIf exMem ();
    memWbIf memWb ();

    fetchStage #(
        .imemDepth(imemDepth)
    ) u_fetch (
        .clk(clk), .rst(rst),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .running(running), .stall(stall), .flushFront(flushFront),
        .redirect(redirect), .redirectPc(redirectPc),
        .ifIdInstr(ifIdInstr), .ifIdPcNext(ifIdPcNext)
    );

    decodeStage u_decode (
        .clk(clk), .rst(rst),
        .ifIdInstr(ifIdInstr), .ifIdPcNext(ifIdPcNext),
        .stall(stall), .flushFront(flushFront),
        .idEx(idEx.producer), .memWb(memWb.consumer), .decHalt(decHalt)
    );

    executeStage u_execute (
        .clk(clk), .rst(rst), .fwdA(fwdA), .fwdB(fwdB),
        .idEx(idEx.consumer), .memWb(memWb.monitor), .exMem(exMem.producer),
        .redirect(redirect), .redirectPc(redirectPc)
    );

    memoryStage #(
        .dmemDepth(dmemDepth)
    ) u_memory (
        .clk(clk), .rst(rst), .exMem(exMem.consumer), .memWb(memWb.producer)
    );

    hazardControl u_hazard (
        .clk(clk), .rst(rst), .start(start), .decHalt(decHalt),
        .redirect(redirect), .ifIdInstr(ifIdInstr),
        .idEx(idEx.monitor), .exMem(exMem.monitor), .memWb(memWb.monitor),
        .stall(stall), .flushFront(flushFront), .running(running),
        .halted(halted), .fwdA(fwdA), .fwdB(fwdB)
    );

    // Observation port, writes to r0 are not shown
    assign wbValid = memWb.regWrite && memWb.destIdx != '0;
    assign wbReg = memWb.destIdx;
    assign wbData = memWb.writeData;

endmodule

`default_nettype wire

/* tbClock.sv */
`default_nettype none

module tbClock (
    output logic clk
);
    // Free running, period of 4
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* tbTop.sv */
`default_nettype none

module tbTop
    import isaPkg::*;
#(
    parameter int imemDepth = 64,
    parameter int dmemDepth = 64
);
    localparam int addrBits = $clog2(imemDepth);
    localparam int dAddrBits = $clog2(dmemDepth);
    localparam functT fnList [5] = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt};

    logic                    clk;
    logic                    rst;
    logic                    imemWe;
    logic [addrBits-1:0]     imemAddr;
    logic [wordWidth-1:0]    imemData;
    logic                    start;
    logic                    wbValid;
    logic [regAddrWidth-1:0] wbReg;
    logic [wordWidth-1:0]    wbData;
    logic                    halted;

    // All programs back to back
    logic [wordWidth-1:0] progWords [$];
    int                   progBase [4];
    int                   progLen [4];
    string                progName [4];

    // Reference model state kept across programs like the DUT
    logic [wordWidth-1:0] modelRegs [32];
    logic [wordWidth-1:0] modelMem [dmemDepth];

    // Expected write-back order
    logic [regAddrWidth-1:0] expReg [$];
    logic [wordWidth-1:0]    expData [$];

    string  testName = "reset";
    logic   idleWatch = 1'b0;
    integer seed;
    int     cycleCount = 0;
    int     cycleLimit = 0;
    int     valueErrors = 0;
    int     extraWrites = 0;
    int     missingWrites = 0;
    int     timeouts = 0;

    tbClock u_clock (
        .clk(clk)
    );

    pipelineCpu #(
        .imemDepth(imemDepth),
        .dmemDepth(dmemDepth)
    ) u_dut (
        .clk(clk), .rst(rst),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .start(start),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .halted(halted)
    );

    // add rd, rs, rt
    function automatic logic [wordWidth-1:0] encR(input functT fn,
            input logic [regAddrWidth-1:0] rd, rs, rt);
        return {opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    // addi rt, rs, imm and sw rt, imm(rs)
    function automatic logic [wordWidth-1:0] encI(input opcodeT op,
            input logic [regAddrWidth-1:0] rt, rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [wordWidth-1:0] encJ(input logic [25:0] target);
        return {opJ, target};
    endfunction

    task automatic emit(input logic [wordWidth-1:0] w);
        progWords.push_back(w);
    endtask

    task automatic openProgram(input int idx, input string name);
        progBase[idx] = progWords.size();
        progName[idx] = name;
    endtask

    task automatic closeProgram(input int idx);
        progLen[idx] = progWords.size() - progBase[idx];
    endtask

    // Back-to-back and one-apart dependencies
    task automatic buildChain(input int idx);
        openProgram(idx, "aluChain");
        emit(encI(opAddi, 5'd1, 5'd0, 16'd5));
        emit(encI(opAddi, 5'd2, 5'd0, 16'hfffd));
        emit(encR(fnAdd, 5'd3, 5'd1, 5'd2));
        emit(encR(fnSub, 5'd4, 5'd3, 5'd1));
        emit(encR(fnAnd, 5'd5, 5'd4, 5'd3));
        emit(encR(fnOr, 5'd6, 5'd5, 5'd1));
        emit(encR(fnSlt, 5'd7, 5'd2, 5'd6));
        emit(encR(fnSlt, 5'd8, 5'd6, 5'd2));
        emit(encI(opAddi, 5'd9, 5'd7, 16'd100));
        emit(encR(fnAdd, 5'd10, 5'd9, 5'd9));
        emit(haltWord);
        closeProgram(idx);
    endtask

    // Store then load with loaded values used at once
    task automatic buildMemory(input int idx);
        openProgram(idx, "storeLoad");
        emit(encI(opAddi, 5'd11, 5'd0, 16'd77));
        emit(encI(opAddi, 5'd12, 5'd0, 16'd9));
        emit(encI(opSw, 5'd11, 5'd12, 16'd3));
        emit(encI(opLw, 5'd13, 5'd12, 16'd3));
        emit(encR(fnAdd, 5'd14, 5'd13, 5'd11));
        emit(encI(opLw, 5'd15, 5'd12, 16'd3));
        // Load feeding the store data
        emit(encI(opSw, 5'd15, 5'd0, 16'd20));
        emit(encI(opLw, 5'd16, 5'd0, 16'd20));
        emit(encI(opAddi, 5'd17, 5'd16, 16'd1));
        emit(haltWord);
        closeProgram(idx);
    endtask

    // Skipped words write r20, r21, r23 and r24
    task automatic buildBranch(input int idx);
        openProgram(idx, "branchJump");
        emit(encI(opAddi, 5'd18, 5'd0, 16'd4));
        emit(encI(opAddi, 5'd19, 5'd0, 16'd4));
        emit(encI(opBeq, 5'd19, 5'd18, 16'd2));
        emit(encI(opAddi, 5'd20, 5'd0, 16'd111));
        emit(encI(opAddi, 5'd21, 5'd0, 16'd222));
        emit(encI(opBeq, 5'd0, 5'd18, 16'd1));
        emit(encI(opAddi, 5'd22, 5'd0, 16'd33));
        emit(encJ(26'd10));
        emit(encI(opAddi, 5'd23, 5'd0, 16'd444));
        emit(encI(opAddi, 5'd24, 5'd0, 16'd555));
        emit(encI(opAddi, 5'd25, 5'd22, 16'd1));
        emit(haltWord);
        closeProgram(idx);
    endtask

    task automatic buildRandom(input int idx);
        int                      kind;
        logic [regAddrWidth-1:0] rd;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [15:0]             imm;
        openProgram(idx, "random");
        for (int i = 0; i < 20; i++) begin
            kind = {$random(seed)} % 6;
            rd = 5'({$random(seed)} % 8);
            rs = 5'({$random(seed)} % 8);
            rt = 5'({$random(seed)} % 8);
            imm = 16'($random(seed));
            if (kind == 5) begin
                emit(encI(opAddi, rd, rs, imm));
            end else begin
                emit(encR(fnList[kind], rd, rs, rt));
            end
        end
        emit(haltWord);
        // Words past the halt must never commit
        emit(encI(opAddi, 5'd1, 5'd0, 16'h0bad));
        emit(encI(opAddi, 5'd2, 5'd0, 16'h0bad));
        closeProgram(idx);
    endtask

    // Instruction-level model that queues each nonzero register write
    task automatic runModel(input int idx);
        logic [wordWidth-1:0]    w;
        logic [wordWidth-1:0]    a;
        logic [wordWidth-1:0]    b;
        logic [wordWidth-1:0]    imm;
        logic [wordWidth-1:0]    res;
        logic [regAddrWidth-1:0] dest;
        logic                    writes;
        int                      pc;
        int                      steps;
        pc = 0;
        steps = 0;
        while (steps < 200 && pc < progLen[idx]) begin
            w = progWords[progBase[idx] + pc];
            if (w == haltWord) begin
                break;
            end
            a = modelRegs[w[25:21]];
            b = modelRegs[w[20:16]];
            imm = {{16{w[15]}}, w[15:0]};
            dest = w[20:16];
            res = a + imm;
            writes = 1'b1;
            pc = pc + 1;
            case (w[31:26])
                opRType: begin
                    dest = w[15:11];
                    case (w[5:0])
                        fnAdd:   res = a + b;
                        fnSub:   res = a - b;
                        fnAnd:   res = a & b;
                        fnOr:    res = a | b;
                        fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;
                    endcase
                end
                opAddi: res = a + imm;
                opLw:   res = modelMem[res[dAddrBits-1:0]];
                opSw: begin
                    modelMem[res[dAddrBits-1:0]] = b;
                    writes = 1'b0;
                end
                // Target is pcNext plus the offset
                opBeq: begin
                    if (a == b) begin
                        pc = pc + int'($signed(imm));
                    end
                    writes = 1'b0;
                end
                opJ: begin
                    pc = int'(w[25:0]);
                    writes = 1'b0;
                end
                default: writes = 1'b0;
            endcase
            if (writes && dest != '0) begin
                modelRegs[dest] = res;
                expReg.push_back(dest);
                expData.push_back(res);
            end
            steps++;
        end
    endtask

    task automatic loadProgram(input int idx);
        for (int i = 0; i < progLen[idx]; i++) begin
            @(posedge clk);
            imemWe <= 1'b1;
            imemAddr <= addrBits'(i);
            imemData <= progWords[progBase[idx] + i];
        end
        @(posedge clk);
        imemWe <= 1'b0;
    endtask

    task automatic runProgram(input int idx);
        testName = progName[idx];
        runModel(idx);
        loadProgram(idx);
        @(posedge clk);
        start <= 1'b1;
        idleWatch = 1'b0;
        @(posedge clk);
        start <= 1'b0;
        do begin
            @(negedge clk);
        end while (!halted);
        @(negedge clk);
        assert (expReg.size() == 0) else begin
            missingWrites += expReg.size();
            $display("%s: %0d expected writes never appeared", testName, expReg.size());
        end
        expReg.delete();
        expData.delete();
    endtask

    task automatic finishRun();
        $display("Error counts: value %0d, unexpected %0d, missing %0d, timeout %0d",
                 valueErrors, extraWrites, missingWrites, timeouts);
        if (valueErrors + extraWrites + missingWrites + timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // Write-back and idle checks mid-cycle
    always @(negedge clk) begin
        if (idleWatch) begin
            assert (!halted && !wbValid) else begin
                valueErrors++;
                $display("Fail reset: expected halted=0 wbValid=0 actual halted=%b wbValid=%b",
                         halted, wbValid);
            end
        end
        if (!rst && wbValid) begin
            assert (expReg.size() > 0) else begin
                extraWrites++;
                $display("%s: unexpected write of %h to r%0d", testName, wbData, wbReg);
            end
            if (expReg.size() > 0) begin
                assert (wbReg == expReg[0] && wbData == expData[0]) else begin
                    valueErrors++;
                    $display("Fail %s: expected r%0d=%h actual r%0d=%h",
                             testName, expReg[0], expData[0], wbReg, wbData);
                end
                void'(expReg.pop_front());
                void'(expData.pop_front());
            end
        end
    end

    // Watchdog
    initial begin
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        timeouts++;
        $display("Timeout: the DUT did not halt within %0d cycles", cycleLimit);
        finishRun();
    end

    initial begin
        seed = 16;
        rst = 1'b1;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        start = 1'b0;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        buildChain(0);
        buildMemory(1);
        buildBranch(2);
        buildRandom(3);
        // Five cycles per instruction plus fixed overhead
        cycleLimit = 5 * progWords.size() + 200;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        idleWatch = 1'b1;
        // Idle stretch before the first start
        repeat (6) @(posedge clk);
        for (int t = 0; t < 4; t++) begin
            runProgram(t);
        end
        // Late writes after the last halt
        repeat (8) @(posedge clk);
        finishRun();
    end

endmodule

`default_nettype wire

/* flist.f */
isaPkg.sv
pipePkg.sv
pipeIfs.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
hazardControl.sv
pipelineCpu.sv
tbClock.sv
tbTop.sv

/* run.sh */
#!/bin/bash
# Build with Verilator, run, and judge the simulation log
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module tbTop \
        -f flist.f -o simTb > build.log 2>&1 \
    && ./obj_dir/simTb | tee sim.log \
    && ! grep -q "TESTS FAILED" sim.log \
    && grep -q "TESTS PASSED" sim.log \
    || { cat build.log 2>/dev/null; echo "Simulation did not pass"; exit 1; }
